//--- Bender.yml
package:
  name: camif

sources:
  - files:
      - source/camif_pkg.sv
      - source/camif_bus_pkg.sv
      - source/pixel_capture.sv
      - source/pixel_fifo.sv
      - source/host_bus_slave.sv
      - source/burst_irq.sv
      - source/camif_top.sv
  - target: test
    files:
      - test/camif_tb.sv

//--- source/burst_irq.sv
`timescale 1ns/1ns
/* one interrupt per BURST_WORDS words; it drops on the first data pop of the burst
   and rearms only after the whole burst has been popped */
module burst_irq (
   input  logic              i_pinclk,
   input  logic              i_rst,
   input  logic              i_irq_en,
   input  camif_pkg::level_t i_level,
   input  logic              i_pop,
   output logic              o_irq
);

   localparam int CW = $clog2(camif_pkg::BURST_WORDS);

   typedef enum logic [1:0]
   {
      IRQ_WAIT,
      IRQ_RAISED,
      IRQ_DRAIN
   } irq_state_t;

   irq_state_t     state;
   logic [CW-1:0]  pop_cnt;
   logic           burst_ready;

   assign burst_ready = (i_level >= camif_pkg::level_t'(camif_pkg::BURST_WORDS));

   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         state   <= IRQ_WAIT;
         pop_cnt <= '0;
         o_irq   <= 1'b0;
      end
      else if (!i_irq_en)
      begin
         state   <= IRQ_WAIT;
         pop_cnt <= '0;
         o_irq   <= 1'b0;
      end
      else
      begin
         case (state)
            IRQ_WAIT:
               if (burst_ready)
               begin
                  o_irq <= 1'b1;
                  state <= IRQ_RAISED;
               end
            IRQ_RAISED:
               if (i_pop)
               begin
                  // the first pop already counts toward the burst
                  o_irq   <= 1'b0;
                  pop_cnt <= CW'(1);
                  state   <= IRQ_DRAIN;
               end
            IRQ_DRAIN:
               if (i_pop)
               begin
                  pop_cnt <= pop_cnt + 1'b1;
                  if (pop_cnt == CW'(camif_pkg::BURST_WORDS - 1))
                     state <= IRQ_WAIT;
               end
            default:
               state <= IRQ_WAIT;
         endcase
      end
   end

endmodule

//--- source/camif_bus_pkg.sv
/* host bus register map; only one register exists, status on read, control on write
   bit positions of the control fields match their status read-back */
package camif_bus_pkg;

   // latched multiplexed address
   typedef logic [15:0] addr_t;

   // address bit 15 high selects the pixel data window
   localparam int DATA_WINDOW_BIT = 15;

   // ********************************************************
   // control fields, written and read back at the same bits
   // ********************************************************
   localparam int CTRL_RGB_BIT    = 15;
   localparam int CTRL_ENABLE_BIT = 12;
   localparam int CTRL_IRQ_EN_BIT = 11;

   // ********************************************************
   // status only fields
   // ********************************************************
   localparam int STAT_OVERFLOW_BIT = 9;
   localparam int STAT_EMPTY_BIT    = 8;

   // fixed identification in status bits 7..0
   localparam logic [7:0] CAMIF_ID = 8'h05;

   // bus slave sequencing
   typedef enum logic [1:0]
   {
      BUS_IDLE,
      BUS_ADDR,
      BUS_ACCESS
   } bus_state_t;

endpackage

//--- source/camif_pkg.sv
/* pixel, word and FIFO sizing shared by the capture path and the interrupt logic
   RGB packing assumes two kept pixel slices fill exactly one word */
package camif_pkg;

   // ********************************************************
   // sensor side
   // ********************************************************

   // one sample of the 10-bit parallel sensor bus
   typedef logic [9:0] pixel_t;

   // upper pixel bits kept per pixel when two pixels share a word
   localparam int PIXEL_MSB_BITS = 8;

   // ********************************************************
   // buffer side
   // ********************************************************

   // FIFO entry and host bus data word
   typedef logic [15:0] word_t;

   // capacity in words
   localparam int FIFO_DEPTH = 64;

   // fill level, has to reach FIFO_DEPTH itself
   typedef logic [$clog2(FIFO_DEPTH + 1) - 1:0] level_t;

   // words per host interrupt
   localparam int BURST_WORDS = 16;

endpackage

//--- source/camif_top.sv
`timescale 1ns/1ns
/* single clock design, the host bus is sampled on pinclk */
module camif_top (
   input  logic              i_pinclk,
   input  logic              i_rst,
   input  logic              i_frame_valid,
   input  logic              i_line_valid,
   input  camif_pkg::pixel_t i_pixel,
   input  logic              i_csn,
   input  logic              i_advn,
   input  logic              i_oen,
   input  logic              i_wen,
   input  camif_pkg::word_t  i_ad,
   output camif_pkg::word_t  o_ad,
   output logic              o_ad_oe,
   output logic              o_irq
);

   logic              push;
   camif_pkg::word_t  push_data;
   logic              pop;
   logic              flush;
   camif_pkg::word_t  rd_data;
   camif_pkg::level_t level;
   logic              empty;
   logic              overflow;
   logic              enable;
   logic              rgb_mode;
   logic              irq_en;

   pixel_capture u_capture (
      .i_pinclk      (i_pinclk),
      .i_rst         (i_rst),
      .i_frame_valid (i_frame_valid),
      .i_line_valid  (i_line_valid),
      .i_pixel       (i_pixel),
      .i_enable      (enable),
      .i_rgb_mode    (rgb_mode),
      .o_push        (push),
      .o_push_data   (push_data)
   );

   // full reaches the host only as the overflow flag
   pixel_fifo u_fifo (
      .i_pinclk    (i_pinclk),
      .i_rst       (i_rst),
      .i_flush     (flush),
      .i_push      (push),
      .i_push_data (push_data),
      .i_pop       (pop),
      .o_rd_data   (rd_data),
      .o_level     (level),
      .o_full      (),
      .o_empty     (empty),
      .o_overflow  (overflow)
   );

   host_bus_slave u_bus (
      .i_pinclk     (i_pinclk),
      .i_rst        (i_rst),
      .i_csn        (i_csn),
      .i_advn       (i_advn),
      .i_oen        (i_oen),
      .i_wen        (i_wen),
      .i_ad         (i_ad),
      .i_fifo_data  (rd_data),
      .i_fifo_empty (empty),
      .i_overflow   (overflow),
      .o_ad         (o_ad),
      .o_ad_oe      (o_ad_oe),
      .o_pop        (pop),
      .o_flush      (flush),
      .o_enable     (enable),
      .o_rgb_mode   (rgb_mode),
      .o_irq_en     (irq_en)
   );

   burst_irq u_irq (
      .i_pinclk (i_pinclk),
      .i_rst    (i_rst),
      .i_irq_en (irq_en),
      .i_level  (level),
      .i_pop    (pop),
      .o_irq    (o_irq)
   );

endmodule

//--- source/host_bus_slave.sv
`timescale 1ns/1ns
/* host strobes are sampled on pinclk and must stay low for at least two cycles
   one action per strobe; read data follows one cycle after the first strobe cycle */
module host_bus_slave (
   input  logic             i_pinclk,
   input  logic             i_rst,
   input  logic             i_csn,
   input  logic             i_advn,
   input  logic             i_oen,
   input  logic             i_wen,
   input  camif_pkg::word_t i_ad,
   input  camif_pkg::word_t i_fifo_data,
   input  logic             i_fifo_empty,
   input  logic             i_overflow,
   output camif_pkg::word_t o_ad,
   output logic             o_ad_oe,
   output logic             o_pop,
   output logic             o_flush,
   output logic             o_enable,
   output logic             o_rgb_mode,
   output logic             o_irq_en
);

   camif_bus_pkg::bus_state_t state;
   camif_bus_pkg::bus_state_t state_next;
   camif_bus_pkg::addr_t      addr;
   camif_pkg::word_t          status;
   logic                      addr_phase;
   logic                      rd_strobe;
   logic                      wr_strobe;
   logic                      rd_start;
   logic                      wr_start;
   logic                      data_sel;
   logic                      overflow;

   assign addr_phase = ~i_csn & ~i_advn;
   assign rd_strobe  = ~i_csn & ~i_oen & i_advn;
   assign wr_strobe  = ~i_csn & ~i_wen & i_advn;
   assign data_sel   = addr[camif_bus_pkg::DATA_WINDOW_BIT];

   // only the cycle that leaves BUS_ADDR acts, later strobe cycles are ignored
   assign rd_start = (state == camif_bus_pkg::BUS_ADDR) & rd_strobe;
   assign wr_start = (state == camif_bus_pkg::BUS_ADDR) & wr_strobe & ~rd_strobe;
   assign o_pop    = rd_start & data_sel & ~i_fifo_empty;

   always_comb
   begin
      status = '0;
      status[camif_bus_pkg::CTRL_RGB_BIT]      = o_rgb_mode;
      status[camif_bus_pkg::CTRL_ENABLE_BIT]   = o_enable;
      status[camif_bus_pkg::CTRL_IRQ_EN_BIT]   = o_irq_en;
      status[camif_bus_pkg::STAT_OVERFLOW_BIT] = overflow;
      status[camif_bus_pkg::STAT_EMPTY_BIT]    = i_fifo_empty;
      status[7:0] = camif_bus_pkg::CAMIF_ID;
   end

   // ********************************************************
   // bus sequencing
   // ********************************************************
   always_comb
   begin
      state_next = state;
      case (state)
         camif_bus_pkg::BUS_IDLE:
            if (addr_phase)
               state_next = camif_bus_pkg::BUS_ADDR;
         camif_bus_pkg::BUS_ADDR:
            if (i_csn)
               state_next = camif_bus_pkg::BUS_IDLE;
            else if (rd_strobe || wr_strobe)
               state_next = camif_bus_pkg::BUS_ACCESS;
         camif_bus_pkg::BUS_ACCESS:
            if (i_csn)
               state_next = camif_bus_pkg::BUS_IDLE;
            else if (addr_phase || (!rd_strobe && !wr_strobe))
               state_next = camif_bus_pkg::BUS_ADDR;
         default:
            state_next = camif_bus_pkg::BUS_IDLE;
      endcase
   end

   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         state   <= camif_bus_pkg::BUS_IDLE;
         addr    <= '0;
         o_ad_oe <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (addr_phase)
            addr <= i_ad;
         o_ad_oe <= rd_start | (o_ad_oe & rd_strobe);
      end
   end

   // ********************************************************
   // control register and sticky overflow
   // ********************************************************
   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         o_rgb_mode <= 1'b0;
         o_enable   <= 1'b0;
         o_irq_en   <= 1'b0;
         o_flush    <= 1'b0;
         overflow   <= 1'b0;
      end
      else
      begin
         o_flush <= 1'b0;
         if (wr_start && !data_sel)
         begin
            o_rgb_mode <= i_ad[camif_bus_pkg::CTRL_RGB_BIT];
            o_enable   <= i_ad[camif_bus_pkg::CTRL_ENABLE_BIT];
            o_irq_en   <= i_ad[camif_bus_pkg::CTRL_IRQ_EN_BIT];
            // flush on a rising enable only
            o_flush    <= i_ad[camif_bus_pkg::CTRL_ENABLE_BIT] & ~o_enable;
         end
         if (i_overflow)
            overflow <= 1'b1;
         else if (rd_start && !data_sel)
            overflow <= 1'b0;
      end
   end

   // read data, an empty data window reads as zero
   always_ff @(posedge i_pinclk)
   begin
      if (rd_start)
      begin
         if (!data_sel)
            o_ad <= status;
         else if (i_fifo_empty)
            o_ad <= '0;
         else
            o_ad <= i_fifo_data;
      end
   end

endmodule

//--- source/pixel_capture.sv
`timescale 1ns/1ns
/* three register stages from the sensor pins to o_push; the sensor is never stalled
   capture arms on a frame_valid rise seen while enabled, so a partial frame is skipped */
module pixel_capture (
   input  logic              i_pinclk,
   input  logic              i_rst,
   input  logic              i_frame_valid,
   input  logic              i_line_valid,
   input  camif_pkg::pixel_t i_pixel,
   input  logic              i_enable,
   input  logic              i_rgb_mode,
   output logic              o_push,
   output camif_pkg::word_t  o_push_data
);

   localparam int PIX_W = $bits(camif_pkg::pixel_t);
   localparam int MSB_W = camif_pkg::PIXEL_MSB_BITS;

   logic              fv_q;
   logic              fv_q2;
   logic              lv_q;
   logic              fv_rise;
   logic              armed;
   logic              arm_now;
   logic              din_valid;
   logic              pair_odd;
   camif_pkg::pixel_t pix_q;
   camif_pkg::pixel_t pix_d;
   logic [MSB_W-1:0]  hi_byte;

   assign fv_rise = fv_q & ~fv_q2;
   // arm in the same cycle as the frame edge so the first pixel is kept
   assign arm_now = armed | (fv_rise & i_enable);

   // ********************************************************
   // sensor sampling and qualification
   // ********************************************************
   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         fv_q      <= 1'b0;
         fv_q2     <= 1'b0;
         lv_q      <= 1'b0;
         armed     <= 1'b0;
         din_valid <= 1'b0;
      end
      else
      begin
         fv_q  <= i_frame_valid;
         fv_q2 <= fv_q;
         lv_q  <= i_line_valid;
         if (!i_enable)
            armed <= 1'b0;
         else if (fv_rise)
            armed <= 1'b1;
         din_valid <= fv_q & lv_q & arm_now & i_enable;
      end
   end

   // ********************************************************
   // packing
   // ********************************************************
   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         o_push   <= 1'b0;
         pair_odd <= 1'b0;
      end
      else
      begin
         o_push <= 1'b0;
         if (din_valid)
         begin
            if (i_rgb_mode)
            begin
               // second pixel of a pair completes the word
               o_push   <= pair_odd;
               pair_odd <= ~pair_odd;
            end
            else
            begin
               o_push   <= 1'b1;
               pair_odd <= 1'b0;
            end
         end
         if (!i_enable)
            pair_odd <= 1'b0;
      end
   end

   always_ff @(posedge i_pinclk)
   begin
      pix_q <= i_pixel;
      pix_d <= pix_q;
      if (din_valid)
      begin
         if (!i_rgb_mode)
            o_push_data <= camif_pkg::word_t'(pix_d);
         else if (!pair_odd)
            hi_byte <= pix_d[PIX_W-1 -: MSB_W];
         else
            o_push_data <= {hi_byte, pix_d[PIX_W-1 -: MSB_W]};
      end
   end

endmodule

//--- source/pixel_fifo.sv
`timescale 1ns/1ns
/* head word is shown on o_rd_data without a read latency; a push into a full FIFO
   is dropped and reported on o_overflow one cycle later, stored words stay intact */
module pixel_fifo (
   input  logic              i_pinclk,
   input  logic              i_rst,
   input  logic              i_flush,
   input  logic              i_push,
   input  camif_pkg::word_t  i_push_data,
   input  logic              i_pop,
   output camif_pkg::word_t  o_rd_data,
   output camif_pkg::level_t o_level,
   output logic              o_full,
   output logic              o_empty,
   output logic              o_overflow
);

   localparam int AW = $clog2(camif_pkg::FIFO_DEPTH);

   camif_pkg::word_t mem [camif_pkg::FIFO_DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign o_full    = (o_level == camif_pkg::level_t'(camif_pkg::FIFO_DEPTH));
   assign o_empty   = (o_level == '0);
   assign do_push   = i_push & ~o_full & ~i_flush;
   assign do_pop    = i_pop & ~o_empty & ~i_flush;
   assign o_rd_data = mem[rd_ptr];

   always_ff @(posedge i_pinclk or posedge i_rst)
   begin
      if (i_rst)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         o_level    <= '0;
         o_overflow <= 1'b0;
      end
      else if (i_flush)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         o_level    <= '0;
         o_overflow <= 1'b0;
      end
      else
      begin
         o_overflow <= i_push & o_full;
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   o_level <= o_level + 1'b1;
            2'b01:   o_level <= o_level - 1'b1;
            default: o_level <= o_level;
         endcase
      end
   end

   // storage
   always_ff @(posedge i_pinclk)
   begin
      if (do_push)
         mem[wr_ptr] <= i_push_data;
   end

endmodule

//--- src.f
source/camif_pkg.sv
source/camif_bus_pkg.sv
source/pixel_capture.sv
source/pixel_fifo.sv
source/host_bus_slave.sv
source/burst_irq.sv
source/camif_top.sv
test/camif_tb.sv

//--- test/camif_tb.sv
`timescale 1ns/1ns
/* inputs change on the falling edge; host strobes are held two cycles
   RGB entries use an even pixel count per frame so every pixel pair completes */
module camif_tb;

   localparam int NUM_TESTS = 7;
   localparam camif_pkg::word_t REG_ADDR  = 16'h0000;
   localparam camif_pkg::word_t DATA_ADDR = 16'h8000;

   typedef struct {
      string name;
      bit    rgb;
      bit    irq_en;
      int    lines;
      int    ppl;
      bit    mid_enable;
      bit    exp_overflow;
      bit    exp_irq;
   } test_t;

   // name, rgb, irq_en, lines, pixels per line, enable mid-frame, overflow, irq
   test_t tests [NUM_TESTS] = '{
      '{"raw_frame",        1'b0, 1'b0, 3, 8,  1'b0, 1'b0, 1'b0},
      '{"rgb_frame",        1'b1, 1'b0, 4, 10, 1'b0, 1'b0, 1'b0},
      '{"enable_mid_frame", 1'b0, 1'b0, 2, 12, 1'b1, 1'b0, 1'b0},
      '{"overflow",         1'b0, 1'b0, 5, 16, 1'b0, 1'b1, 1'b0},
      '{"irq_enabled",      1'b0, 1'b1, 2, 12, 1'b0, 1'b0, 1'b1},
      '{"irq_disabled",     1'b0, 1'b0, 2, 12, 1'b0, 1'b0, 1'b0},
      '{"rgb_irq",          1'b1, 1'b1, 4, 8,  1'b0, 1'b0, 1'b1}
   };

   logic              pinclk = 1'b0;
   logic              rst;
   logic              frame_valid;
   logic              line_valid;
   camif_pkg::pixel_t pixel;
   logic              csn;
   logic              advn;
   logic              oen;
   logic              wen;
   camif_pkg::word_t  ad;
   camif_pkg::word_t  o_ad;
   logic              o_ad_oe;
   logic              o_irq;

   logic [31:0]       lcg_state = 32'd16350;
   camif_pkg::pixel_t pixels [$];
   camif_pkg::word_t  exp_words [$];
   string             cur_name;
   int                errors = 0;
   int                tests_failed = 0;
   int                cycles = 0;
   int                cycle_limit = 1000;

   camif_top i_dut (
      .i_pinclk      (pinclk),
      .i_rst         (rst),
      .i_frame_valid (frame_valid),
      .i_line_valid  (line_valid),
      .i_pixel       (pixel),
      .i_csn         (csn),
      .i_advn        (advn),
      .i_oen         (oen),
      .i_wen         (wen),
      .i_ad          (ad),
      .o_ad          (o_ad),
      .o_ad_oe       (o_ad_oe),
      .o_irq         (o_irq)
   );

   initial
   begin
      forever #50 pinclk = ~pinclk;
   end

   always @(posedge pinclk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   // ********************************************************
   // reference model
   // ********************************************************
   function automatic camif_pkg::pixel_t next_pixel();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[25:16];
   endfunction

   function automatic camif_pkg::word_t control_word(bit rgb, bit en, bit irq_en);
      camif_pkg::word_t w;
      w = '0;
      w[camif_bus_pkg::CTRL_RGB_BIT]    = rgb;
      w[camif_bus_pkg::CTRL_ENABLE_BIT] = en;
      w[camif_bus_pkg::CTRL_IRQ_EN_BIT] = irq_en;
      return w;
   endfunction

   function automatic camif_pkg::word_t expected_status(bit rgb, bit en, bit irq_en,
                                                        bit ovf, bit empty);
      camif_pkg::word_t s;
      s = control_word(rgb, en, irq_en);
      s[camif_bus_pkg::STAT_OVERFLOW_BIT] = ovf;
      s[camif_bus_pkg::STAT_EMPTY_BIT]    = empty;
      s[7:0] = 8'h05;
      return s;
   endfunction

   // raw keeps each pixel zero-extended and rgb joins the upper bytes of a pair
   task automatic pack_expected(input bit rgb);
      int i;
      exp_words.delete();
      if (!rgb)
      begin
         for (i = 0; i < pixels.size(); i++)
            exp_words.push_back({6'b0, pixels[i]});
      end
      else
      begin
         for (i = 0; i + 1 < pixels.size(); i += 2)
            exp_words.push_back({pixels[i][9:2], pixels[i + 1][9:2]});
      end
   endtask

   task automatic check_value(input string what, input int expected, input int actual);
      assert (expected == actual)
      else
      begin
         $display("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                  cur_name, what, expected, actual);
         errors++;
      end
   endtask

   // ********************************************************
   // host bus and sensor models
   // ********************************************************
   task automatic bus_write(input camif_pkg::word_t addr, input camif_pkg::word_t data);
      @(negedge pinclk);
      csn  = 1'b0;
      advn = 1'b0;
      ad   = addr;
      @(negedge pinclk);
      advn = 1'b1;
      wen  = 1'b0;
      ad   = data;
      @(negedge pinclk);
      @(negedge pinclk);
      csn = 1'b1;
      wen = 1'b1;
   endtask

   task automatic bus_read(input camif_pkg::word_t addr, output camif_pkg::word_t data);
      int waited;
      waited = 0;
      @(negedge pinclk);
      csn  = 1'b0;
      advn = 1'b0;
      ad   = addr;
      @(negedge pinclk);
      advn = 1'b1;
      oen  = 1'b0;
      @(negedge pinclk);
      while (!o_ad_oe && waited < 8)
      begin
         @(negedge pinclk);
         waited++;
      end
      assert (o_ad_oe)
      else
      begin
         $display("%s: the bus never flagged read data as valid", cur_name);
         errors++;
      end
      data = o_ad;
      // a second strobe cycle keeps the data and starts no new access
      @(negedge pinclk);
      assert (o_ad_oe && o_ad == data)
      else
      begin
         $display("%s: read data did not hold while the strobe stayed low", cur_name);
         errors++;
      end
      csn  = 1'b1;
      oen  = 1'b1;
      @(negedge pinclk);
      assert (!o_ad_oe)
      else
      begin
         $display("%s: output enable stayed high after the strobe ended", cur_name);
         errors++;
      end
   endtask

   // frame_valid leads the first line; the idle tail covers the capture latency
   task automatic send_frame(input int lines, input int ppl, input bit capture);
      int l;
      int p;
      @(negedge pinclk);
      frame_valid = 1'b1;
      repeat (2) @(negedge pinclk);
      for (l = 0; l < lines; l++)
      begin
         for (p = 0; p < ppl; p++)
         begin
            pixel      = next_pixel();
            line_valid = 1'b1;
            if (capture)
               pixels.push_back(pixel);
            @(negedge pinclk);
         end
         line_valid = 1'b0;
         repeat (2) @(negedge pinclk);
      end
      frame_valid = 1'b0;
      repeat (4) @(negedge pinclk);
   endtask

   // ********************************************************
   // test sequences
   // ********************************************************
   task automatic report_test(input int err_start);
      if (errors == err_start)
         $display("test %-18s ok", cur_name);
      else
      begin
         $display("test %-18s failed with %0d errors", cur_name, errors - err_start);
         tests_failed++;
      end
   endtask

   task automatic check_reset_state();
      camif_pkg::word_t got;
      cur_name = "reset_state";
      bus_read(REG_ADDR, got);
      check_value("status", expected_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), got);
      check_value("irq", 0, o_irq);
      report_test(0);
   endtask

   task automatic run_test(input test_t t);
      camif_pkg::word_t ctrl;
      camif_pkg::word_t got;
      int n_read;
      int err_start;
      int i;
      cur_name  = t.name;
      err_start = errors;
      pixels.delete();
      ctrl = control_word(t.rgb, 1'b1, t.irq_en);
      // disabled first so capture disarms and the rgb pairing restarts
      bus_write(REG_ADDR, '0);
      if (t.mid_enable)
      begin
         fork
            send_frame(t.lines, t.ppl, 1'b0);
            begin
               repeat (8) @(negedge pinclk);
               bus_write(REG_ADDR, ctrl);
            end
         join
      end
      else
         bus_write(REG_ADDR, ctrl);
      send_frame(t.lines, t.ppl, 1'b1);
      pack_expected(t.rgb);
      n_read = (exp_words.size() < camif_pkg::FIFO_DEPTH) ? exp_words.size()
                                                           : camif_pkg::FIFO_DEPTH;
      check_value("irq after frame", t.exp_irq, o_irq);
      bus_read(REG_ADDR, got);
      check_value("status after frame",
                  expected_status(t.rgb, 1'b1, t.irq_en, t.exp_overflow, n_read == 0), got);
      for (i = 0; i < n_read; i++)
      begin
         bus_read(DATA_ADDR, got);
         check_value($sformatf("word %0d", i), exp_words[i], got);
         if (i == 0)
            check_value("irq after first read", 0, o_irq);
      end
      bus_read(REG_ADDR, got);
      check_value("status after drain",
                  expected_status(t.rgb, 1'b1, t.irq_en, 1'b0, 1'b1), got);
      bus_read(DATA_ADDR, got);
      check_value("read of empty FIFO", 0, got);
      report_test(err_start);
   endtask

   initial
   begin
      rst         = 1'b1;
      frame_valid = 1'b0;
      line_valid  = 1'b0;
      pixel       = '0;
      csn         = 1'b1;
      advn        = 1'b1;
      oen         = 1'b1;
      wen         = 1'b1;
      ad          = '0;
      // mid-frame entries send the frame twice
      for (int k = 0; k < NUM_TESTS; k++)
         cycle_limit += 4 * (tests[k].lines * tests[k].ppl * (tests[k].mid_enable ? 3 : 2) + 3);
      repeat (4) @(negedge pinclk);
      rst = 1'b0;
      check_reset_state();
      for (int k = 0; k < NUM_TESTS; k++)
         run_test(tests[k]);
      $display("%0d tests, %0d failed, %0d check errors", NUM_TESTS + 1, tests_failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
